//--- Bender.yml
package:
  name: heart_rate_monitor

sources:
  - include_dirs:
      - logic
    files:
      - logic/hrmSamplePkg.sv
      - logic/hrmRatePkg.sv
      - logic/spiSampleIn.sv
      - logic/firFilter.sv
      - logic/peakDetector.sv
      - logic/rateCounter.sv
      - logic/heartRateMonitor.sv
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/tbHeartRate.sv

//--- list.f
+incdir+logic
+incdir+tests
logic/hrmSamplePkg.sv
logic/hrmRatePkg.sv
logic/spiSampleIn.sv
logic/firFilter.sv
logic/peakDetector.sv
logic/rateCounter.sv
logic/heartRateMonitor.sv
tests/tbHeartRate.sv

//--- logic/firFilter.sv
// symmetric FIR low-pass with one output per input strobe and one cycle latency
// output clamps at full scale when the gain pushes past 10 bits
`timescale 1ns/1ps
`default_nettype none

`include "hrm_cfg.svh"

module firFilter
(
	input  wire logic                 sck,
	input  wire logic                 reset,
	input  wire hrmSamplePkg::sample_t sample,
	input  wire logic                 sampleValid,
	output hrmSamplePkg::sample_t     filtered,
	output logic                      filteredValid
);

	import hrmSamplePkg::*;

	localparam int CENTRE = (`HRM_FIR_TAPS - 1) / 2;
	// one bit past the accumulator for the clamp
	localparam int SUM_W  = $bits(acc_t) + 1;

	// delay line with tap 0 the oldest
	sample_t taps    [`HRM_FIR_TAPS];
	// delay line as it will be after this strobe
	sample_t nextTap [`HRM_FIR_TAPS];
	logic [`HRM_SAMPLE_BITS:0] pairSum;
	logic [SUM_W-1:0] sumWide;
	acc_t acc;
	logic overflow;

	// shifted view where the newest sample lands on the last tap
	always_comb
	begin
		for (int k = 0; k < `HRM_FIR_TAPS - 1; k++)
			nextTap[k] = taps[k + 1];
		nextTap[`HRM_FIR_TAPS - 1] = sample;
	end

	// fold mirrored taps before one multiply per coefficient
	always_comb
	begin
		sumWide = '0;
		pairSum = '0;
		for (int k = 0; k < CENTRE; k++)
		begin
			pairSum = {1'b0, nextTap[k]} + {1'b0, nextTap[`HRM_FIR_TAPS - 1 - k]};
			sumWide = sumWide + SUM_W'(firCoefs[k]) * SUM_W'(pairSum);
		end
		// centre tap stands alone
		sumWide = sumWide + SUM_W'(firCoefs[CENTRE]) * SUM_W'(nextTap[CENTRE]);
	end

	assign acc = sumWide[SUM_W-2:0];
	// top bit set means the shifted result exceeds full scale
	assign overflow = sumWide[SUM_W-1];

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			for (int k = 0; k < `HRM_FIR_TAPS; k++)
				taps[k] <= '0;
			filtered      <= '0;
			filteredValid <= 1'b0;
		end
		else
		begin
			filteredValid <= sampleValid;
			if (sampleValid)
			begin
				taps     <= nextTap;
				filtered <= overflow ? '1 : sample_t'(acc >> `HRM_FIR_SHIFT);
			end
		end
	end

	// output strobe tracks input strobe by exactly one cycle
	assert property (@(posedge sck) disable iff (reset)
		filteredValid == $past(sampleValid))
		else $error("filteredValid out of step with sampleValid");

endmodule

`default_nettype wire

//--- logic/heartRateMonitor.sv
// heart-rate monitor top: serial in, low-pass, peak find, rate report
// all stages run on sck rising edge and never stall
`timescale 1ns/1ps
`default_nettype none

`include "hrm_cfg.svh"

module heartRateMonitor
#(
	parameter int WINDOW_CYCLES = `HRM_WINDOW_CYCLES
)
(
	input  wire logic                 sck,
	input  wire logic                 reset,
	input  wire logic                 sdo,
	output hrmSamplePkg::sample_t     filtered,
	output logic                      filteredValid,
	output logic                      peakPulse,
	output hrmRatePkg::bpm_t          heartRate,
	output hrmRatePkg::peakCount_t    peakCount,
	output logic                      rateValid
);

	import hrmSamplePkg::*;

	// raw sample from the receiver
	sample_t sample;
	logic sampleValid;

	spiSampleIn u_spiSampleIn (
		.sck         (sck),
		.reset       (reset),
		.sdo         (sdo),
		.sample      (sample),
		.sampleValid (sampleValid)
	);

	firFilter u_firFilter (
		.sck           (sck),
		.reset         (reset),
		.sample        (sample),
		.sampleValid   (sampleValid),
		.filtered      (filtered),
		.filteredValid (filteredValid)
	);

	peakDetector u_peakDetector (
		.sck           (sck),
		.reset         (reset),
		.filtered      (filtered),
		.filteredValid (filteredValid),
		.peakPulse     (peakPulse)
	);

	rateCounter #(
		.WINDOW_CYCLES (WINDOW_CYCLES)
	) u_rateCounter (
		.sck       (sck),
		.reset     (reset),
		.peakPulse (peakPulse),
		.heartRate (heartRate),
		.peakCount (peakCount),
		.rateValid (rateValid)
	);

endmodule

`default_nettype wire

//--- logic/hrmRatePkg.sv
// rate reporting types
// bpm width covers a saturated peak count times the scale
`default_nettype none

package hrmRatePkg;

	// peaks in one window, saturating
	typedef logic [7:0] peakCount_t;

	// beats per minute, 255 * 6 fits
	typedef logic [11:0] bpm_t;

endpackage

`default_nettype wire

//--- logic/hrmSamplePkg.sv
// sample path types and the low-pass coefficient table
// table holds only the first half plus centre; the filter mirrors it
`default_nettype none

`include "hrm_cfg.svh"

package hrmSamplePkg;

	// raw and filtered samples share one width
	typedef logic [`HRM_SAMPLE_BITS-1:0] sample_t;

	// accumulator, twice the sample width
	// a full-scale input carries one bit past this, the filter clamps it
	typedef logic [2*`HRM_SAMPLE_BITS-1:0] acc_t;

	// one coefficient, unsigned
	typedef logic [7:0] coef_t;

	// unique taps of the symmetric filter
	localparam int FIR_HALF = (`HRM_FIR_TAPS + 1) / 2;

	// outermost tap first, centre tap last
	// sum over all 31 taps is 1028, a touch over unity gain
	localparam coef_t firCoefs [FIR_HALF] = '{
		8'd3,  8'd4,  8'd6,  8'd8,
		8'd12, 8'd17, 8'd23, 8'd29,
		8'd36, 8'd43, 8'd50, 8'd56,
		8'd61, 8'd65, 8'd67, 8'd68
	};

endpackage

`default_nettype wire

//--- logic/hrm_cfg.svh
// shared sizing for the monitor pipeline; one sample per frame of sck cycles
// window default assumes sck near 1.25 MHz, so 12.5M cycles is about 10 s
`ifndef HRM_CFG_SVH
`define HRM_CFG_SVH

// sck cycles per serial frame, data MSB first
`define HRM_FRAME_BITS 16

// significant bits kept from each frame
`define HRM_SAMPLE_BITS 10

// symmetric low-pass, odd tap count
`define HRM_FIR_TAPS 31
// coefficients are scaled by 2^10
`define HRM_FIR_SHIFT 10

// slope history, split into two halves
`define HRM_HISTORY_LEN 128
// older half must have few falling slopes
`define HRM_LEFT_MAX 55
// newer half must have many falling slopes
`define HRM_RIGHT_MIN 40
// samples blocked after a peak
`define HRM_HOLD_SAMPLES 128

// rate window in sck cycles
`define HRM_WINDOW_CYCLES 12500000
// beats per minute per peak in a 10 s window
`define HRM_BPM_SCALE 6

`endif

//--- logic/peakDetector.sv
// peak finder over a slope history; fires when falling slopes move into the newer half
// hold-off counts samples rather than cycles
`timescale 1ns/1ps
`default_nettype none

`include "hrm_cfg.svh"

module peakDetector
(
	input  wire logic                 sck,
	input  wire logic                 reset,
	input  wire hrmSamplePkg::sample_t filtered,
	input  wire logic                 filteredValid,
	output logic                      peakPulse
);

	import hrmSamplePkg::*;

	localparam int HALF   = `HRM_HISTORY_LEN / 2;
	localparam int SUM_W  = $clog2(HALF + 1);
	localparam int HOLD_W = $clog2(`HRM_HOLD_SAMPLES + 1);

	sample_t prevSample;
	// one bit per sample set for a flat or falling step with bit 0 newest
	logic [`HRM_HISTORY_LEN-1:0] history;
	// ones in the newer and older halves
	logic [SUM_W-1:0] rightSum;
	logic [SUM_W-1:0] leftSum;
	// samples left in the hold-off
	logic [HOLD_W-1:0] holdCount;
	logic newBit;
	logic peakFound;

	// not rising counts as falling
	assign newBit = (filtered <= prevSample);

	// sums as they stand before this sample
	assign peakFound = (leftSum <= SUM_W'(`HRM_LEFT_MAX))
		&& (rightSum >= SUM_W'(`HRM_RIGHT_MIN))
		&& (holdCount == '0);

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			prevSample <= '0;
			// all falling so a rising start cannot fire early
			history    <= '1;
			rightSum   <= SUM_W'(HALF);
			leftSum    <= SUM_W'(HALF);
			holdCount  <= '0;
			peakPulse  <= 1'b0;
		end
		else
		begin
			// one-cycle strobe
			peakPulse <= 1'b0;
			if (filteredValid)
			begin
				prevSample <= filtered;
				history    <= {history[`HRM_HISTORY_LEN-2:0], newBit};
				// bit leaving the newer half enters the older half
				rightSum   <= rightSum + SUM_W'(newBit) - SUM_W'(history[HALF-1]);
				leftSum    <= leftSum + SUM_W'(history[HALF-1])
					- SUM_W'(history[`HRM_HISTORY_LEN-1]);

				if (peakFound)
				begin
					peakPulse <= 1'b1;
					holdCount <= HOLD_W'(`HRM_HOLD_SAMPLES);
				end
				else if (holdCount != '0)
				begin
					holdCount <= holdCount - 1'b1;
				end
			end
		end
	end

	// a pulse only follows a sample seen with no hold-off running
	assert property (@(posedge sck) disable iff (reset)
		peakPulse |-> ($past(holdCount) == '0) && $past(filteredValid))
		else $error("peakPulse during hold-off");

endmodule

`default_nettype wire

//--- logic/rateCounter.sv
// counts peaks over a fixed window of sck cycles and reports bpm at each window end
// window restarts after every report; peak count saturates
`timescale 1ns/1ps
`default_nettype none

`include "hrm_cfg.svh"

module rateCounter
#(
	parameter int WINDOW_CYCLES = `HRM_WINDOW_CYCLES
)
(
	input  wire logic                 sck,
	input  wire logic                 reset,
	input  wire logic                 peakPulse,
	output hrmRatePkg::bpm_t          heartRate,
	output hrmRatePkg::peakCount_t    peakCount,
	output logic                      rateValid
);

	import hrmRatePkg::*;

	localparam int CYC_W = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;

	logic [CYC_W-1:0] cycleCount;
	// peaks in the running window
	peakCount_t peaks;
	logic windowEnd;

	assign windowEnd = (cycleCount == CYC_W'(WINDOW_CYCLES - 1));

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			cycleCount <= '0;
			peaks      <= '0;
			heartRate  <= '0;
			peakCount  <= '0;
			rateValid  <= 1'b0;
		end
		else
		begin
			rateValid <= windowEnd;
			if (windowEnd)
			begin
				cycleCount <= '0;
				peakCount  <= peaks;
				heartRate  <= bpm_t'(peaks) * bpm_t'(`HRM_BPM_SCALE);
				// a peak on the boundary belongs to the new window
				peaks      <= peakCount_t'(peakPulse);
			end
			else
			begin
				cycleCount <= cycleCount + 1'b1;
				if (peakPulse && (peaks != '1))
					peaks <= peaks + 1'b1;
			end
		end
	end

	// report stays a whole multiple of the scale
	assert property (@(posedge sck) disable iff (reset)
		heartRate % `HRM_BPM_SCALE == 0)
		else $error("heartRate %0d not a multiple of the scale", heartRate);

endmodule

`default_nettype wire

//--- logic/spiSampleIn.sv
// serial sample receiver, MSB first, frame alignment fixed by reset
// only the low bits of each frame are kept; upper bits are ignored
`timescale 1ns/1ps
`default_nettype none

`include "hrm_cfg.svh"

module spiSampleIn
(
	input  wire logic                 sck,
	input  wire logic                 reset,
	input  wire logic                 sdo,
	output hrmSamplePkg::sample_t     sample,
	output logic                      sampleValid
);

	import hrmSamplePkg::*;

	localparam int CNT_W = $clog2(`HRM_FRAME_BITS);

	// position in frame, 0 takes the MSB
	logic [CNT_W-1:0] bitCount;
	// incoming bits, newest at bit 0
	logic [`HRM_FRAME_BITS-1:0] shiftReg;
	logic frameDone;

	// last bit of the frame arrives this edge
	assign frameDone = (bitCount == CNT_W'(`HRM_FRAME_BITS - 1));

	// frame counter and strobe
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			bitCount    <= '0;
			sampleValid <= 1'b0;
		end
		else
		begin
			bitCount    <= bitCount + 1'b1;
			sampleValid <= frameDone;
		end
	end

	// data path, no reset needed
	always_ff @(posedge sck)
	begin
		shiftReg <= {shiftReg[`HRM_FRAME_BITS-2:0], sdo};
		// include the bit arriving now
		if (frameDone)
			sample <= sample_t'({shiftReg[`HRM_FRAME_BITS-2:0], sdo});
	end

	// one strobe per frame at most
	assert property (@(posedge sck) disable iff (reset)
		sampleValid |=> !sampleValid)
		else $error("sampleValid high in consecutive cycles");

endmodule

`default_nettype wire

//--- tests/tbModel.svh
// reference model of the filter, peak and rate rules, included inside the testbench module
// reads stim, numSamples and WINDOW, fills expFilt and peakAt
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// outer tap first, centre last; mirrored for the upper half
localparam int COEF [16] = '{3, 4, 6, 8, 12, 17, 23, 29, 36, 43, 50, 56, 61, 65, 67, 68};
localparam int CENTRE_TAP = (`HRM_FIR_TAPS - 1) / 2;
localparam int HALF = `HRM_HISTORY_LEN / 2;

// filtered value after sample i, delay line empty at reset
function automatic int firAt(input int i);
	int sum;
	int j;
	sum = 0;
	for (int k = 0; k < `HRM_FIR_TAPS; k++)
	begin
		// tap 30 holds sample i
		j = i - (`HRM_FIR_TAPS - 1) + k;
		if (j >= 0)
			sum += COEF[(k > CENTRE_TAP) ? `HRM_FIR_TAPS - 1 - k : k] * stim[j];
	end
	sum = sum >>> `HRM_FIR_SHIFT;
	return (sum > 1023) ? 1023 : sum;
endfunction

// walks the stream once, fills filter and peak expectations
task automatic modelRun();
	bit [`HRM_HISTORY_LEN-1:0] hist;
	int prev;
	int hold;
	int left;
	int right;
	bit falling;
	hist = '1;
	prev = 0;
	hold = 0;
	for (int i = 0; i < numSamples; i++)
	begin
		expFilt[i] = firAt(i);
		// halves counted from scratch, before this sample
		left = 0;
		right = 0;
		for (int b = 0; b < `HRM_HISTORY_LEN; b++)
		begin
			if (b < HALF)
				right += hist[b];
			else
				left += hist[b];
		end
		falling = (expFilt[i] <= prev);
		peakAt[i] = (left <= `HRM_LEFT_MAX) && (right >= `HRM_RIGHT_MIN) && (hold == 0);
		if (peakAt[i])
			hold = `HRM_HOLD_SAMPLES;
		else if (hold > 0)
			hold--;
		hist = {hist[`HRM_HISTORY_LEN-2:0], falling};
		prev = expFilt[i];
	end
endtask

// peaks whose pulse lands in window w, saturated like the counter
function automatic int windowPeaks(input int w);
	int count;
	count = 0;
	for (int i = 0; i < numSamples; i++)
	begin
		if (peakAt[i] && ((`HRM_FRAME_BITS * i + FIRST_FILT + 1) / WINDOW == w))
			count++;
	end
	return (count > 255) ? 255 : count;
endfunction

`endif

//--- tests/tbHeartRate.sv
// drives framed serial samples through the monitor and checks every strobe against a model
// frame 0 starts on the edge that releases reset; short rate window of 16384 cycles
`timescale 1ns/1ps
`default_nettype none

`include "hrm_cfg.svh"

module tbHeartRate;

	import hrmSamplePkg::*;
	import hrmRatePkg::*;

	localparam int WINDOW = 16384;
	localparam int N_RANDOM = 200;
	localparam int N_SAT = 64;
	localparam int N_TRIANGLE = 3100;
	localparam int MAX_N = N_TRIANGLE;
	// cycle of the first filter strobe after release
	localparam int FIRST_FILT = `HRM_FRAME_BITS + 2;
	// each stream is followed by two idle frames
	localparam int TOTAL_FRAMES = N_RANDOM + N_SAT + N_TRIANGLE + 3 * 2;
	localparam real WATCHDOG_NS = TOTAL_FRAMES * `HRM_FRAME_BITS * 4.0 * 1.2;
	localparam int T_RESET = 0;
	localparam int T_FILTER = 1;
	localparam int T_SAT = 2;
	localparam int T_PEAK = 3;
	localparam int T_RATE = 4;
	localparam int N_TESTS = 5;

	logic sck;
	logic reset;
	logic sdo;
	sample_t filtered;
	logic filteredValid;
	logic peakPulse;
	bpm_t heartRate;
	peakCount_t peakCount;
	logic rateValid;

	integer seed = 32'h5399;
	int stim [MAX_N];
	int expFilt [MAX_N];
	bit peakAt [MAX_N];
	int numSamples;
	// test that owns the filter checks of the current stream
	int filtTest;
	// rising edges since the release edge
	int cycle;
	int lastPeak;
	int reports;
	int resetCycles;
	int errCount [N_TESTS];
	int checkCount [N_TESTS];
	string testName [N_TESTS] = '{"reset", "filter", "saturation", "peak", "rate"};

	`include "tbModel.svh"

	heartRateMonitor #(
		.WINDOW_CYCLES (WINDOW)
	) u_dut (
		.sck           (sck),
		.reset         (reset),
		.sdo           (sdo),
		.filtered      (filtered),
		.filteredValid (filteredValid),
		.peakPulse     (peakPulse),
		.heartRate     (heartRate),
		.peakCount     (peakCount),
		.rateValid     (rateValid)
	);

	initial
	begin
		sck = 1'b0;
		forever #2 sck = ~sck;
	end

	task automatic checkValue(input int t, input string what, input int expected,
		input int actual);
		checkCount[t]++;
		assert (expected == actual)
		else
		begin
			$display("FAILED %s %s: expected %0d, actual %0d", testName[t], what,
				expected, actual);
			errCount[t]++;
		end
	endtask

	task automatic requireTrue(input int t, input bit ok, input string msg);
		checkCount[t]++;
		assert (ok)
		else
		begin
			$display("%s test: %s", testName[t], msg);
			errCount[t]++;
		end
	endtask

	// reset then serialize n samples MSB first plus two zero frames
	task automatic runStream(input int n, input int t);
		logic [15:0] word;
		@(posedge sck);
		reset <= 1'b1;
		sdo <= 1'b0;
		repeat (16) @(posedge sck);
		numSamples = n;
		filtTest = t;
		modelRun();
		// release edge also carries bit 15 of frame 0
		reset <= 1'b0;
		for (int f = 0; f < n + 2; f++)
		begin
			word = (f < n) ? 16'(stim[f]) : 16'h0;
			for (int b = `HRM_FRAME_BITS - 1; b >= 0; b--)
			begin
				sdo <= word[b];
				@(posedge sck);
			end
		end
	endtask

	task automatic reportTest(input int t);
		$display("test %s: %s, %0d checks, %0d errors", testName[t],
			(errCount[t] == 0) ? "ok" : "errors", checkCount[t], errCount[t]);
	endtask

	// outputs sampled on the rising edge before the DUT updates
	always @(posedge sck)
	begin
		int idx;
		bit want;
		bit idle;
		idle = !filteredValid && !peakPulse && !rateValid && (filtered == 0)
			&& (heartRate == 0) && (peakCount == 0);
		if (reset)
		begin
			cycle = 0;
			lastPeak = -1;
			reports = 0;
			resetCycles++;
			// first reset edge may still show power-up values
			if (resetCycles > 1)
				requireTrue(T_RESET, idle, "outputs not idle during reset");
		end
		else
		begin
			resetCycles = 0;
			cycle = cycle + 1;
			if (cycle < FIRST_FILT)
				requireTrue(T_RESET, idle, "outputs active before the first frame completed");
			// filter strobe every frame from FIRST_FILT on
			want = (cycle >= FIRST_FILT) && ((cycle - FIRST_FILT) % `HRM_FRAME_BITS == 0);
			checkValue(filtTest, "filteredValid", want, filteredValid);
			idx = (cycle - FIRST_FILT) / `HRM_FRAME_BITS;
			if (filteredValid && (cycle >= FIRST_FILT) && (idx < numSamples))
			begin
				checkValue(filtTest, $sformatf("filtered[%0d]", idx), expFilt[idx], filtered);
				// delay line full of full-scale values
				if ((filtTest == T_SAT) && (idx >= `HRM_FIR_TAPS - 1))
					checkValue(T_SAT, $sformatf("clamp[%0d]", idx), 1023, filtered);
			end
			// peak pulse trails its filter strobe by one cycle
			if (cycle < `HRM_FRAME_BITS * numSamples + FIRST_FILT + 1)
			begin
				idx = (cycle - FIRST_FILT - 1) / `HRM_FRAME_BITS;
				want = (cycle > FIRST_FILT)
					&& ((cycle - FIRST_FILT - 1) % `HRM_FRAME_BITS == 0) && peakAt[idx];
				checkValue(T_PEAK, $sformatf("peakPulse at cycle %0d", cycle), want, peakPulse);
			end
			if (peakPulse)
			begin
				if (lastPeak >= 0)
					requireTrue(T_PEAK, (cycle - lastPeak) >= `HRM_HOLD_SAMPLES * `HRM_FRAME_BITS,
						$sformatf("two peaks only %0d cycles apart", cycle - lastPeak));
				lastPeak = cycle;
			end
			// report one cycle after each window end
			want = (cycle > WINDOW) && ((cycle - 1) % WINDOW == 0);
			checkValue(T_RATE, "rateValid", want, rateValid);
			if (rateValid)
			begin
				idx = (cycle - 1) / WINDOW - 1;
				checkValue(T_RATE, $sformatf("peakCount window %0d", idx),
					windowPeaks(idx), peakCount);
				checkValue(T_RATE, $sformatf("heartRate window %0d", idx),
					`HRM_BPM_SCALE * windowPeaks(idx), heartRate);
				reports++;
			end
		end
	end

	initial
	begin
		int total;
		int bad;
		reset = 1'b1;
		sdo = 1'b0;
		numSamples = 0;
		filtTest = T_FILTER;
		resetCycles = 0;
		// random 10-bit samples
		for (int i = 0; i < N_RANDOM; i++)
			stim[i] = $random(seed) & 32'h3ff;
		runStream(N_RANDOM, T_FILTER);
		reportTest(T_FILTER);
		// constant full scale
		for (int i = 0; i < N_SAT; i++)
			stim[i] = 1023;
		runStream(N_SAT, T_SAT);
		reportTest(T_SAT);
		// triangle with 100 up and 100 down
		for (int i = 0; i < N_TRIANGLE; i++)
			stim[i] = (i % 200 < 100) ? 200 + 5 * (i % 200) : 200 + 5 * (200 - i % 200);
		runStream(N_TRIANGLE, T_PEAK);
		checkValue(T_RATE, "reports seen", (cycle - 1) / WINDOW, reports);
		reportTest(T_RESET);
		reportTest(T_PEAK);
		reportTest(T_RATE);
		total = 0;
		bad = 0;
		for (int t = 0; t < N_TESTS; t++)
		begin
			total += errCount[t];
			if (errCount[t] != 0)
				bad++;
		end
		$display("summary: %0d tests, %0d clean, %0d with errors, %0d errors in total",
			N_TESTS, N_TESTS - bad, bad, total);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// limit from total frames plus a fifth
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0t", $time);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
